//--- common/periph_pkg.sv
// Peripheral window definitions

package periph_pkg;

	// ----------------------------------------------------------------------
	// bus and payload types
	// ----------------------------------------------------------------------

	// byte offset inside the peripheral window
	typedef logic [15:0] addr_t;

	// register data word
	typedef logic [31:0] data_t;

	// machine timer count and compare
	typedef logic [63:0] mtime_t;

	// uart transmit payload
	typedef logic [7:0] uart_byte_t;

	// ----------------------------------------------------------------------
	// register map
	// ----------------------------------------------------------------------

	// low address bits that do not take part in decode
	localparam int BYTE_OFS_BITS = 2;

	// uart block base, bit 14 picks the block
	localparam addr_t UART_BASE = 16'h4000;

	// timer block at offset zero
	localparam addr_t TIMER_CTRL_OFS     = 16'h0000;
	localparam addr_t TIMER_MTIME_LO_OFS = 16'h0008;
	localparam addr_t TIMER_MTIME_HI_OFS = 16'h000c;
	localparam addr_t TIMER_CMP_LO_OFS   = 16'h0010;
	localparam addr_t TIMER_CMP_HI_OFS   = 16'h0014;

	// uart registers
	localparam addr_t UART_TXDATA_OFS = UART_BASE + 16'h0000;
	localparam addr_t UART_STATUS_OFS = UART_BASE + 16'h0004;

	// control register fields
	localparam int TIMER_CTRL_EN_BIT = 0;

	// status register fields
	localparam int UART_STATUS_BUSY_BIT = 0;

endpackage

//--- src/periph_ctrl.sv
// Register port decoder
`timescale 1ns/1ps

module periph_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	input  logic                   req_write,
	input  periph_pkg::addr_t      req_addr,
	input  periph_pkg::data_t      req_wdata,
	input  periph_pkg::data_t      timer_rdata,
	input  logic                   uart_busy,
	output logic                   rsp_valid,
	output periph_pkg::data_t      rsp_rdata,
	output logic                   rsp_err,
	output logic                   timer_wr,
	output logic [2:0]             timer_sel,
	output periph_pkg::data_t      timer_wdata,
	output logic                   uart_wr,
	output periph_pkg::uart_byte_t uart_wdata
);

	localparam int AW      = $bits(periph_pkg::addr_t);
	localparam int BLK_BIT = $clog2(periph_pkg::UART_BASE);
	localparam int WW      = AW - periph_pkg::BYTE_OFS_BITS;

	// word index of a register offset
	function automatic logic [WW-1:0] word_of(input periph_pkg::addr_t ofs);
		return ofs[AW-1:periph_pkg::BYTE_OFS_BITS];
	endfunction

	logic [WW-1:0]     word;
	logic              blk_uart;
	logic              hit_timer;
	logic              hit_txd;
	logic              hit_stat;
	logic              err;
	periph_pkg::data_t rd_val;

	// ----------------------------------------------------------------------
	// address decode
	// ----------------------------------------------------------------------

	assign word     = req_addr[AW-1:periph_pkg::BYTE_OFS_BITS];
	assign blk_uart = req_addr[BLK_BIT];

	assign hit_timer = !blk_uart && (
		word == word_of(periph_pkg::TIMER_CTRL_OFS) ||
		word == word_of(periph_pkg::TIMER_MTIME_LO_OFS) ||
		word == word_of(periph_pkg::TIMER_MTIME_HI_OFS) ||
		word == word_of(periph_pkg::TIMER_CMP_LO_OFS) ||
		word == word_of(periph_pkg::TIMER_CMP_HI_OFS));

	assign hit_txd  = blk_uart && word == word_of(periph_pkg::UART_TXDATA_OFS);
	assign hit_stat = blk_uart && word == word_of(periph_pkg::UART_STATUS_OFS);

	// unmapped, status write, or tx write while a frame is running
	assign err = !(hit_timer || hit_txd || hit_stat) ||
		(req_write && hit_stat) ||
		(req_write && hit_txd && uart_busy);

	// ----------------------------------------------------------------------
	// peripheral strobes
	// ----------------------------------------------------------------------

	assign timer_sel   = req_addr[periph_pkg::BYTE_OFS_BITS +: 3];
	assign timer_wr    = req_valid && req_write && hit_timer;
	assign timer_wdata = req_wdata;

	// a busy uart drops the byte
	assign uart_wr    = req_valid && req_write && hit_txd && !uart_busy;
	assign uart_wdata = req_wdata[$bits(periph_pkg::uart_byte_t)-1:0];

	// read mux, txdata reads as zero
	always_comb begin
		rd_val = '0;
		if (hit_timer) begin
			rd_val = timer_rdata;
		end else if (hit_stat) begin
			rd_val[periph_pkg::UART_STATUS_BUSY_BIT] = uart_busy;
		end
	end

	// ----------------------------------------------------------------------
	// response, one cycle after the request
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			rsp_err   <= 1'b0;
		end else begin
			rsp_valid <= req_valid;
			rsp_err   <= req_valid && err;
		end
	end

	always_ff @(posedge clk) begin
		rsp_rdata <= (req_valid && !req_write && !err) ? rd_val : '0;
	end

	// an accepted byte keeps the uart busy from the next cycle on
	a_txd_sets_busy: assert property (
		@(posedge clk) disable iff (!rst_n) uart_wr |=> uart_busy);

endmodule

//--- timer/us_tick_gen.sv
// Microsecond tick generator
`timescale 1ns/1ps

module us_tick_gen #(
	parameter int CLK_MHZ = 27
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	localparam int CTR_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;
	localparam logic [CTR_W-1:0] RELOAD = CTR_W'(CLK_MHZ - 1);

	logic [CTR_W-1:0] ctr;

	// down-counter, tick on the cycle after it hits zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctr  <= RELOAD;
			tick <= 1'b0;
		end else begin
			if (ctr == '0) begin
				ctr <= RELOAD;
			end else begin
				ctr <= ctr - 1'b1;
			end
			tick <= (ctr == '0);
		end
	end

endmodule

//--- timer/mtime_timer.sv
// RISC-V machine timer
`timescale 1ns/1ps

module mtime_timer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              tick,
	input  logic              halt,
	input  logic              wr,
	input  logic [2:0]        sel,
	input  periph_pkg::data_t wdata,
	output periph_pkg::data_t rdata,
	output logic              timer_irq
);

	localparam int DW = $bits(periph_pkg::data_t);
	localparam int MW = $bits(periph_pkg::mtime_t);

	// register index inside the timer block
	localparam logic [2:0] SEL_CTRL =
		3'(periph_pkg::TIMER_CTRL_OFS >> periph_pkg::BYTE_OFS_BITS);
	localparam logic [2:0] SEL_MTIME_LO =
		3'(periph_pkg::TIMER_MTIME_LO_OFS >> periph_pkg::BYTE_OFS_BITS);
	localparam logic [2:0] SEL_MTIME_HI =
		3'(periph_pkg::TIMER_MTIME_HI_OFS >> periph_pkg::BYTE_OFS_BITS);
	localparam logic [2:0] SEL_CMP_LO =
		3'(periph_pkg::TIMER_CMP_LO_OFS >> periph_pkg::BYTE_OFS_BITS);
	localparam logic [2:0] SEL_CMP_HI =
		3'(periph_pkg::TIMER_CMP_HI_OFS >> periph_pkg::BYTE_OFS_BITS);

	logic               enable;
	periph_pkg::mtime_t mtime;
	periph_pkg::mtime_t mtimecmp;
	logic               mtime_wr;
	logic               count_en;

	assign mtime_wr = wr && (sel == SEL_MTIME_LO || sel == SEL_MTIME_HI);

	// frozen while the hart is halted
	assign count_en = tick && enable && !halt;

	// ----------------------------------------------------------------------
	// registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable    <= 1'b0;
			mtime     <= '0;
			mtimecmp  <= '1;
			timer_irq <= 1'b0;
		end else begin
			if (wr) begin
				case (sel)
					SEL_CTRL:     enable <= wdata[periph_pkg::TIMER_CTRL_EN_BIT];
					SEL_MTIME_LO: mtime[DW-1:0] <= wdata;
					SEL_MTIME_HI: mtime[MW-1:DW] <= wdata;
					SEL_CMP_LO:   mtimecmp[DW-1:0] <= wdata;
					SEL_CMP_HI:   mtimecmp[MW-1:DW] <= wdata;
					default: ;
				endcase
			end
			// a write to mtime wins over the tick
			if (count_en && !mtime_wr) begin
				mtime <= mtime + 1'b1;
			end
			timer_irq <= enable && (mtime >= mtimecmp);
		end
	end

	// ----------------------------------------------------------------------
	// read back
	// ----------------------------------------------------------------------

	always_comb begin
		rdata = '0;
		case (sel)
			SEL_CTRL:     rdata[periph_pkg::TIMER_CTRL_EN_BIT] = enable;
			SEL_MTIME_LO: rdata = mtime[DW-1:0];
			SEL_MTIME_HI: rdata = mtime[MW-1:DW];
			SEL_CMP_LO:   rdata = mtimecmp[DW-1:0];
			SEL_CMP_HI:   rdata = mtimecmp[MW-1:DW];
			default:      rdata = '0;
		endcase
	end

	// count only moves on a tick from the timebase or a bus write
	a_mtime_stable: assert property (
		@(posedge clk) disable iff (!rst_n) !(tick || mtime_wr) |=> $stable(mtime));

endmodule

//--- uart/uart_tx.sv
// UART transmitter
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 234
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wr,
	input  periph_pkg::uart_byte_t wdata,
	output logic                   busy,
	output logic                   tx
);

	localparam int BW     = $bits(periph_pkg::uart_byte_t);
	localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [BAUD_W-1:0] BAUD_RELOAD = BAUD_W'(CLKS_PER_BIT - 1);

	// data bits plus stop bit still to go after the start bit
	localparam logic [3:0] FRAME_REST = 4'(BW + 1);

	logic [BW:0]       shreg;
	logic [3:0]        bits_left;
	logic [BAUD_W-1:0] baud_cnt;
	logic              bit_end;
	logic              shift_en;

	assign bit_end  = busy && (baud_cnt == '0);
	assign shift_en = bit_end && (bits_left != '0);

	// ----------------------------------------------------------------------
	// bit timing and line state
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			tx        <= 1'b1;
			bits_left <= '0;
			baud_cnt  <= '0;
		end else if (wr) begin
			// start bit goes out right away
			busy      <= 1'b1;
			tx        <= 1'b0;
			bits_left <= FRAME_REST;
			baud_cnt  <= BAUD_RELOAD;
		end else if (busy) begin
			if (bit_end) begin
				baud_cnt <= BAUD_RELOAD;
				if (shift_en) begin
					tx        <= shreg[0];
					bits_left <= bits_left - 1'b1;
				end else begin
					// stop bit has run its full period
					busy <= 1'b0;
				end
			end else begin
				baud_cnt <= baud_cnt - 1'b1;
			end
		end
	end

	// data lsb first, stop bit on top
	always_ff @(posedge clk) begin
		if (wr) begin
			shreg <= {1'b1, wdata};
		end else if (shift_en) begin
			shreg <= {1'b1, shreg[BW:1]};
		end
	end

	// decoder must hold writes back during a frame
	a_no_wr_busy: assert property (
		@(posedge clk) disable iff (!rst_n) wr |-> !busy);

endmodule

//--- src/periph_top.sv
// Peripheral subsystem top
`timescale 1ns/1ps

module periph_top #(
	parameter int CLK_MHZ      = 27,
	parameter int CLKS_PER_BIT = 234
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              req_valid,
	input  logic              req_write,
	input  periph_pkg::addr_t req_addr,
	input  periph_pkg::data_t req_wdata,
	input  logic              halt,
	output logic              rsp_valid,
	output periph_pkg::data_t rsp_rdata,
	output logic              rsp_err,
	output logic              timer_irq,
	output logic              uart_tx
);

	logic                   tick;
	logic                   timer_wr;
	logic [2:0]             timer_sel;
	periph_pkg::data_t      timer_wdata;
	periph_pkg::data_t      timer_rdata;
	logic                   uart_wr;
	periph_pkg::uart_byte_t uart_wdata;
	logic                   uart_busy;

	periph_ctrl i_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.req_write   (req_write),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.timer_rdata (timer_rdata),
		.uart_busy   (uart_busy),
		.rsp_valid   (rsp_valid),
		.rsp_rdata   (rsp_rdata),
		.rsp_err     (rsp_err),
		.timer_wr    (timer_wr),
		.timer_sel   (timer_sel),
		.timer_wdata (timer_wdata),
		.uart_wr     (uart_wr),
		.uart_wdata  (uart_wdata)
	);

	us_tick_gen #(.CLK_MHZ(CLK_MHZ)) i_tick (.clk(clk), .rst_n(rst_n), .tick(tick));

	mtime_timer i_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.halt      (halt),
		.wr        (timer_wr),
		.sel       (timer_sel),
		.wdata     (timer_wdata),
		.rdata     (timer_rdata),
		.timer_irq (timer_irq)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (uart_wr),
		.wdata (uart_wdata),
		.busy  (uart_busy),
		.tx    (uart_tx)
	);

endmodule

//--- dv/tb_periph_top.sv
// Peripheral subsystem testbench
`timescale 1ns/1ps

module tb_periph_top;

	localparam int CLK_NS     = 4;
	localparam int TB_CLK_MHZ = 4;
	localparam int BIT_CLKS   = 8;
	localparam int GAP        = 40;
	localparam int IRQ_LIMIT  = 40;

	// rough cycle budget of all tests, doubled for the watchdog
	localparam int TEST_CYCLES = 3 + 16 + 20 + (2 * GAP + 16) + (12 + IRQ_LIMIT) +
		(20 * BIT_CLKS + 40);
	localparam int WATCHDOG_NS = 2 * CLK_NS * TEST_CYCLES;

	logic                 clk;
	logic                 rst_n;
	logic                 req_valid;
	logic                 req_write;
	periph_pkg::addr_t    req_addr;
	periph_pkg::data_t    req_wdata;
	logic                 halt;
	logic                 rsp_valid;
	periph_pkg::data_t    rsp_rdata;
	logic                 rsp_err;
	logic                 timer_irq;
	logic                 uart_tx;

	int seed   = 32'h6eef;
	int errors = 0;
	int checks = 0;
	int tests  = 0;

	periph_top #(.CLK_MHZ(TB_CLK_MHZ), .CLKS_PER_BIT(BIT_CLKS)) i_periph_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.halt      (halt),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_err   (rsp_err),
		.timer_irq (timer_irq),
		.uart_tx   (uart_tx)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------

	task automatic check_data(input string name, input periph_pkg::data_t got,
		input periph_pkg::data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input periph_pkg::uart_byte_t got,
		input periph_pkg::uart_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// bus helpers, all entered 1 ns after a rising edge
	// ----------------------------------------------------------------------

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic reg_access(input logic write, input periph_pkg::addr_t addr,
		input periph_pkg::data_t wdata, output periph_pkg::data_t rdata, output logic err);
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		req_wdata = wdata;
		wait_cycles(1);
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		if (rsp_valid !== 1'b1) begin
			errors++;
			$display("no response one cycle after the request to offset %h", addr);
		end
		rdata = rsp_rdata;
		err   = rsp_err;
	endtask

	task automatic write_reg(input periph_pkg::addr_t addr, input periph_pkg::data_t data,
		input logic exp_err);
		periph_pkg::data_t rd;
		logic              err;
		reg_access(1'b1, addr, data, rd, err);
		check_bit("rsp_err", err, exp_err);
		check_data("rsp_rdata", rd, '0);
	endtask

	task automatic read_check(input string name, input periph_pkg::addr_t addr,
		input periph_pkg::data_t exp);
		periph_pkg::data_t rd;
		logic              err;
		reg_access(1'b0, addr, '0, rd, err);
		check_data(name, rd, exp);
		check_bit("rsp_err", err, 1'b0);
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests++;
		if (errors == errs_at_start) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, errors - errs_at_start);
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	task automatic test_reset_values();
		int e0;
		e0 = errors;
		check_bit("rsp_valid", rsp_valid, 1'b0);
		check_bit("rsp_err", rsp_err, 1'b0);
		check_bit("timer_irq", timer_irq, 1'b0);
		check_bit("uart_tx", uart_tx, 1'b1);
		read_check("timer ctrl", periph_pkg::TIMER_CTRL_OFS, 32'h0);
		read_check("mtime lo", periph_pkg::TIMER_MTIME_LO_OFS, 32'h0);
		read_check("mtime hi", periph_pkg::TIMER_MTIME_HI_OFS, 32'h0);
		read_check("mtimecmp lo", periph_pkg::TIMER_CMP_LO_OFS, 32'hffff_ffff);
		read_check("mtimecmp hi", periph_pkg::TIMER_CMP_HI_OFS, 32'hffff_ffff);
		read_check("uart status", periph_pkg::UART_STATUS_OFS, 32'h0);
		read_check("uart txdata", periph_pkg::UART_TXDATA_OFS, 32'h0);
		// idle cycle, so no response either
		wait_cycles(1);
		check_bit("rsp_valid", rsp_valid, 1'b0);
		finish_test("reset_values", e0);
	endtask

	task automatic test_register_access();
		int                e0;
		periph_pkg::data_t cmp_lo;
		periph_pkg::data_t cmp_hi;
		periph_pkg::data_t mt_lo;
		periph_pkg::data_t mt_hi;
		periph_pkg::data_t rd;
		logic              err;
		e0     = errors;
		cmp_lo = $random(seed);
		cmp_hi = $random(seed);
		mt_lo  = $random(seed);
		mt_hi  = $random(seed);
		write_reg(periph_pkg::TIMER_CMP_LO_OFS, cmp_lo, 1'b0);
		write_reg(periph_pkg::TIMER_CMP_HI_OFS, cmp_hi, 1'b0);
		write_reg(periph_pkg::TIMER_MTIME_LO_OFS, mt_lo, 1'b0);
		write_reg(periph_pkg::TIMER_MTIME_HI_OFS, mt_hi, 1'b0);
		read_check("mtimecmp lo", periph_pkg::TIMER_CMP_LO_OFS, cmp_lo);
		read_check("mtimecmp hi", periph_pkg::TIMER_CMP_HI_OFS, cmp_hi);
		read_check("mtime lo", periph_pkg::TIMER_MTIME_LO_OFS, mt_lo);
		read_check("mtime hi", periph_pkg::TIMER_MTIME_HI_OFS, mt_hi);
		// unmapped read and writes, status is read only
		reg_access(1'b0, 16'h0004, '0, rd, err);
		check_bit("rsp_err", err, 1'b1);
		check_data("rsp_rdata", rd, '0);
		// both offsets alias the mtimecmp lo select in the low address bits
		write_reg(16'h0030, ~cmp_lo, 1'b1);
		write_reg(16'h4010, ~cmp_lo, 1'b1);
		write_reg(periph_pkg::UART_STATUS_OFS, 32'h1, 1'b1);
		read_check("mtimecmp lo", periph_pkg::TIMER_CMP_LO_OFS, cmp_lo);
		read_check("uart status", periph_pkg::UART_STATUS_OFS, 32'h0);
		finish_test("register_access", e0);
	endtask

	task automatic test_mtime_count();
		int                e0;
		periph_pkg::data_t t0;
		periph_pkg::data_t t1;
		periph_pkg::data_t delta;
		logic              err;
		e0 = errors;
		write_reg(periph_pkg::TIMER_CTRL_OFS, 32'h1, 1'b0);
		read_check("timer ctrl", periph_pkg::TIMER_CTRL_OFS, 32'h1);
		// reads are GAP cycles apart
		reg_access(1'b0, periph_pkg::TIMER_MTIME_LO_OFS, '0, t0, err);
		wait_cycles(GAP - 1);
		reg_access(1'b0, periph_pkg::TIMER_MTIME_LO_OFS, '0, t1, err);
		delta = t1 - t0;
		checks++;
		if (delta < GAP / TB_CLK_MHZ - 1 || delta > GAP / TB_CLK_MHZ + 1) begin
			errors++;
			$display("mtime advanced by %0d over %0d cycles, expected about %0d",
				delta, GAP, GAP / TB_CLK_MHZ);
		end
		// halted hart freezes the count
		halt = 1'b1;
		wait_cycles(1);
		reg_access(1'b0, periph_pkg::TIMER_MTIME_LO_OFS, '0, t0, err);
		wait_cycles(GAP - 1);
		reg_access(1'b0, periph_pkg::TIMER_MTIME_LO_OFS, '0, t1, err);
		check_data("mtime lo while halted", t1, t0);
		halt = 1'b0;
		write_reg(periph_pkg::TIMER_CTRL_OFS, 32'h0, 1'b0);
		finish_test("mtime_count", e0);
	endtask

	task automatic test_timer_irq();
		int                e0;
		periph_pkg::data_t cmp;
		periph_pkg::data_t rd;
		logic              err;
		logic              seen;
		e0   = errors;
		seen = 1'b0;
		cmp  = 32'h100 + 32'd3;
		write_reg(periph_pkg::TIMER_MTIME_HI_OFS, 32'h0, 1'b0);
		write_reg(periph_pkg::TIMER_MTIME_LO_OFS, 32'h100, 1'b0);
		write_reg(periph_pkg::TIMER_CMP_HI_OFS, 32'h0, 1'b0);
		write_reg(periph_pkg::TIMER_CMP_LO_OFS, cmp, 1'b0);
		write_reg(periph_pkg::TIMER_CTRL_OFS, 32'h1, 1'b0);
		// read data and irq both reflect the count before the same edge
		for (int i = 0; i < IRQ_LIMIT && !seen; i++) begin
			reg_access(1'b0, periph_pkg::TIMER_MTIME_LO_OFS, '0, rd, err);
			check_bit("timer_irq", timer_irq, rd >= cmp);
			seen = timer_irq;
		end
		if (!seen) begin
			errors++;
			$display("timer_irq did not rise within %0d reads", IRQ_LIMIT);
		end
		write_reg(periph_pkg::TIMER_CMP_LO_OFS, cmp + 32'd100, 1'b0);
		wait_cycles(1);
		check_bit("timer_irq", timer_irq, 1'b0);
		write_reg(periph_pkg::TIMER_CTRL_OFS, 32'h0, 1'b0);
		finish_test("timer_irq", e0);
	endtask

	task automatic test_uart_frame();
		int                     e0;
		periph_pkg::data_t      rnd;
		periph_pkg::data_t      rd;
		periph_pkg::uart_byte_t tx_byte;
		periph_pkg::uart_byte_t rx_byte;
		logic                   err;
		logic                   busy;
		e0      = errors;
		rnd     = $random(seed);
		tx_byte = rnd[7:0];
		rx_byte = '0;
		busy    = 1'b1;
		write_reg(periph_pkg::UART_TXDATA_OFS, {24'h0, tx_byte}, 1'b0);
		read_check("uart status", periph_pkg::UART_STATUS_OFS, 32'h1);
		write_reg(periph_pkg::UART_TXDATA_OFS, {24'h0, ~tx_byte}, 1'b1);
		// middle of the start bit
		wait_cycles(BIT_CLKS / 2 - 2);
		check_bit("uart_tx start bit", uart_tx, 1'b0);
		for (int i = 0; i < 8; i++) begin
			wait_cycles(BIT_CLKS);
			rx_byte[i] = uart_tx;
		end
		check_byte("uart_tx data", rx_byte, tx_byte);
		wait_cycles(BIT_CLKS);
		check_bit("uart_tx stop bit", uart_tx, 1'b1);
		for (int i = 0; i < 2 * BIT_CLKS && busy; i++) begin
			reg_access(1'b0, periph_pkg::UART_STATUS_OFS, '0, rd, err);
			busy = rd[periph_pkg::UART_STATUS_BUSY_BIT];
		end
		if (busy) begin
			errors++;
			$display("uart status still busy well after the stop bit");
		end
		// the dropped byte must not show up as a second frame
		for (int i = 0; i < 10 * BIT_CLKS; i++) begin
			if (uart_tx !== 1'b1) begin
				errors++;
				$display("uart_tx went low after the frame, a dropped byte was sent");
				break;
			end
			wait_cycles(1);
		end
		finish_test("uart_frame", e0);
	endtask

	// ----------------------------------------------------------------------
	// main sequence and watchdog
	// ----------------------------------------------------------------------

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		halt      = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_values();
		test_register_access();
		test_mtime_count();
		test_timer_irq();
		test_uart_frame();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog stopped the run after %0d ns, the tests did not complete",
			WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- all.f
common/periph_pkg.sv
src/periph_ctrl.sv
timer/us_tick_gen.sv
timer/mtime_timer.sv
uart/uart_tx.sv
src/periph_top.sv
dv/tb_periph_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_periph_top
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
